/* source/cp0_pkg.sv */
package cp0_pkg;

    localparam int PABITS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0] creg_addr_t;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_MOD  = 5'd1,
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_CPU  = 5'd11,
        EXC_OV   = 5'd12
    } exc_code_t;

    typedef struct packed {
        logic [3:0] cu;
        logic rp, fr, re, mx, px, bev, ts, sr, nmi;
        logic r18;
        logic [1:0] impl;
        logic [7:0] im;
        logic kx, sx, ux, um, r3, erl, exl, ie;
    } cp0_status_t;

    typedef struct packed {
        logic bd, ti;
        logic [1:0] ce;
        logic dc, pci;
        logic [1:0] zero0;
        logic iv, wp;
        logic [5:0] zero1;
        logic [7:0] ip;
        logic zero2;
        logic [4:0] exccode;
        logic [1:0] zero3;
    } cp0_cause_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0] zero;
        logic [7:0] asid;
    } cp0_entryhi_t;

    typedef struct packed {
        logic p;
        logic [25:0] zero;
        logic [4:0] index;
    } cp0_index_t;

    typedef struct packed {
        logic [8:0] ptebase;
        logic [18:0] badvpn2;
        logic [3:0] zero;
    } cp0_context_t;

    typedef struct packed {
        logic m;
        logic [14:0] impl;
        logic be;
        logic [1:0] at;
        logic [2:0] ar, mt;
        logic [3:0] zero;
        logic [2:0] k0;
    } cp0_config_t;

    typedef struct packed {
        cp0_index_t index;
        word_t random, entrylo0, entrylo1;
        cp0_context_t context_reg;
        word_t wired, badvaddr, count;
        cp0_entryhi_t entryhi;
        word_t compare;
        cp0_status_t status;
        cp0_cause_t cause;
        word_t epc, prid;
        cp0_config_t config0;
        word_t config1;
    } cp0_regs_t;

    typedef struct packed {
        logic wen;
        creg_addr_t addr;
        logic [2:0] sel;
        word_t wd;
    } cp0_write_t;

    typedef struct packed {
        logic valid, in_delay_slot, is_cop1;
        exc_code_t code;
        word_t pc, badvaddr;
    } exception_t;

    localparam word_t PRID_VALUE = 32'h0001_8000;
    // mmu size field holds entries - 1
    localparam word_t CONFIG1_VALUE = 32'h0e00_0000;

    localparam cp0_regs_t CP0_RESET = '{
        status: '{bev: 1'b1, erl: 1'b1, default: '0},
        config0: '{m: 1'b1, mt: 3'd1, k0: 3'd3, default: '0},
        prid: PRID_VALUE,
        config1: CONFIG1_VALUE,
        default: '0
    };

endpackage

/* source/tlb_pkg.sv */
package tlb_pkg;

    import cp0_pkg::*;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_INDEX = $clog2(TLB_ENTRIES);

    // one half of an entry laid out like entrylo[25:1]
    typedef struct packed {
        logic [PABITS-13:0] pfn;
        logic [2:0] c;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0] asid;
        logic g;
        tlb_page_t lo0;
        tlb_page_t lo1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        TLB_NONE,
        TLB_READ,
        TLB_PROBE,
        TLB_WRITE_INDEXED
    } tlb_op_t;

    typedef struct packed {
        word_t entryhi, entrylo0, entrylo1, index;
    } tlb_resp_t;

endpackage

/* source/tlb_if.sv */
`timescale 1ns/1ns

interface tlb_if
    import cp0_pkg::*, tlb_pkg::*;
();

    tlb_op_t op;
    word_t entryhi, entrylo0, entrylo1, index;
    // combinational in the same cycle as op
    tlb_resp_t resp;

    modport cp0 (
        output op, entryhi, entrylo0, entrylo1, index,
        input resp
    );

    modport tlb (
        input op, entryhi, entrylo0, entrylo1, index,
        output resp
    );

endinterface

/* source/cp0.sv */
`timescale 1ns/1ns

module cp0
    import cp0_pkg::*, tlb_pkg::*;
(
    input logic clk,
    input logic reset,
    input cp0_write_t [1:0] cwrite,
    input creg_addr_t [1:0] r_addr,
    input logic [1:0][2:0] r_sel,
    output word_t [1:0] r_data,
    input exception_t exception,
    input logic is_eret,
    input tlb_op_t tlb_op,
    output cp0_regs_t cp0_data,
    output logic timer_interrupt,
    output logic k0_uncached,
    output logic is_usermode,
    output logic bev_valid,
    tlb_if.cp0 tlb
);

    cp0_regs_t regs, regs_next;
    logic count_toggle;
    logic compare_write;

    function automatic word_t read_reg(input cp0_regs_t r, input creg_addr_t addr,
                                       input logic [2:0] sel);
        word_t data;
        data = '0;
        if (sel == 3'd1 && addr == 5'd16) begin
            data = r.config1;
        end else begin
            case (addr)
                5'd0:  data = r.index;
                5'd1:  data = r.random;
                5'd2:  data = r.entrylo0;
                5'd3:  data = r.entrylo1;
                5'd4:  data = r.context_reg;
                5'd6:  data = r.wired;
                5'd8:  data = r.badvaddr;
                5'd9:  data = r.count;
                5'd10: data = r.entryhi;
                5'd11: data = r.compare;
                5'd12: data = r.status;
                5'd13: data = r.cause;
                5'd14: data = r.epc;
                5'd15: data = r.prid;
                5'd16: data = r.config0;
                default: data = '0;
            endcase
        end
        return data;
    endfunction

    // only writable fields change
    function automatic cp0_regs_t apply_write(input cp0_regs_t r, input cp0_write_t w);
        cp0_regs_t res;
        cp0_status_t st;
        cp0_entryhi_t eh;
        res = r;
        st = cp0_status_t'(w.wd);
        eh = cp0_entryhi_t'(w.wd);
        if (w.wen && w.sel == 3'd0) begin
            case (w.addr)
                5'd0:  res.index.index = w.wd[4:0];
                5'd2:  res.entrylo0[PABITS-7:0] = w.wd[PABITS-7:0];
                5'd3:  res.entrylo1[PABITS-7:0] = w.wd[PABITS-7:0];
                5'd4:  res.context_reg.ptebase = w.wd[31:23];
                5'd6:  res.wired[TLB_INDEX-1:0] = w.wd[TLB_INDEX-1:0];
                5'd9:  res.count = w.wd;
                5'd10: begin
                    res.entryhi.vpn2 = eh.vpn2;
                    res.entryhi.asid = eh.asid;
                end
                5'd11: res.compare = w.wd;
                5'd12: begin
                    res.status.cu[0] = st.cu[0];
                    res.status.bev = st.bev;
                    res.status.im = st.im;
                    res.status.um = st.um;
                    res.status.exl = st.exl;
                    res.status.ie = st.ie;
                end
                5'd13: res.cause.ip[1:0] = w.wd[9:8];
                5'd14: res.epc = w.wd;
                5'd16: begin
                    res.config0.impl[14:9] = w.wd[30:25];
                    res.config0.k0 = w.wd[2:0];
                end
                default: ;
            endcase
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!reset) begin
            regs <= CP0_RESET;
            regs.random <= word_t'(TLB_ENTRIES - 1);
            count_toggle <= 1'b1;
        end else begin
            regs <= regs_next;
            count_toggle <= ~count_toggle;
        end
    end

    assign r_data[0] = read_reg(regs, r_addr[0], r_sel[0]);
    assign r_data[1] = read_reg(regs, r_addr[1], r_sel[1]);

    always_comb begin
        compare_write = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (cwrite[i].wen && cwrite[i].sel == 3'd0 && cwrite[i].addr == 5'd11) begin
                compare_write = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            timer_interrupt <= 1'b0;
        end else if (regs.count == regs.compare && regs.compare != '0) begin
            timer_interrupt <= 1'b1;
        end else if (compare_write) begin
            timer_interrupt <= 1'b0;
        end
    end

    // count, slot 1, slot 0, tlb, exception and eret in that order with later ones winning
    always_comb begin
        regs_next = regs;
        regs_next.count = regs.count + word_t'(count_toggle);
        regs_next = apply_write(regs_next, cwrite[1]);
        regs_next = apply_write(regs_next, cwrite[0]);

        if (tlb_op == TLB_READ) begin
            regs_next.entryhi = cp0_entryhi_t'(tlb.resp.entryhi);
            regs_next.entrylo0 = tlb.resp.entrylo0;
            regs_next.entrylo1 = tlb.resp.entrylo1;
        end
        if (tlb_op == TLB_PROBE) begin
            regs_next.index = cp0_index_t'(tlb.resp.index);
        end

        if (exception.valid) begin
            // epc only taken outside an exception handler
            if (!regs.status.exl) begin
                regs_next.cause.bd = exception.in_delay_slot;
                regs_next.epc = exception.in_delay_slot ? exception.pc - 32'd4
                                                        : exception.pc;
            end
            regs_next.cause.exccode = exception.code;
            regs_next.status.exl = 1'b1;
            if (exception.code == EXC_CPU) begin
                regs_next.cause.ce = {1'b0, exception.is_cop1};
            end
            if (exception.code inside {EXC_ADEL, EXC_ADES, EXC_TLBL, EXC_TLBS, EXC_MOD}) begin
                regs_next.badvaddr = exception.badvaddr;
            end
            if (exception.code inside {EXC_TLBL, EXC_TLBS, EXC_MOD}) begin
                regs_next.context_reg.badvpn2 = exception.badvaddr[31:13];
                regs_next.entryhi.vpn2 = exception.badvaddr[31:13];
            end
        end

        if (is_eret) begin
            if (regs.status.erl) begin
                regs_next.status.erl = 1'b0;
            end else begin
                regs_next.status.exl = 1'b0;
            end
        end
    end

    assign tlb.op = tlb_op;
    assign tlb.entryhi = regs.entryhi;
    assign tlb.entrylo0 = regs.entrylo0;
    assign tlb.entrylo1 = regs.entrylo1;
    assign tlb.index = regs.index;

    assign cp0_data = regs;
    assign k0_uncached = regs.config0.k0 == 3'd2;
    assign is_usermode = regs.status.um && !regs.status.erl && !regs.status.exl;
    assign bev_valid = regs.status.bev;

endmodule

/* source/tlb.sv */
`timescale 1ns/1ns

module tlb
    import tlb_pkg::*;
(
    input logic clk,
    input logic reset,
    tlb_if.tlb tlb
);

    tlb_entry_t entries [TLB_ENTRIES];
    tlb_entry_t sel_entry;
    logic [TLB_INDEX-1:0] sel_idx;
    logic [TLB_INDEX-1:0] hit_idx;
    logic hit;

    assign sel_idx = tlb.index[TLB_INDEX-1:0];
    assign sel_entry = entries[sel_idx];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (tlb.op == TLB_WRITE_INDEXED) begin
            entries[sel_idx].vpn2 <= tlb.entryhi[31:13];
            entries[sel_idx].asid <= tlb.entryhi[7:0];
            // global only when both halves say so
            entries[sel_idx].g <= tlb.entrylo0[0] & tlb.entrylo1[0];
            entries[sel_idx].lo0 <= tlb_page_t'(tlb.entrylo0[$bits(tlb_page_t):1]);
            entries[sel_idx].lo1 <= tlb_page_t'(tlb.entrylo1[$bits(tlb_page_t):1]);
        end
    end

    // walk down so the lowest match is kept
    always_comb begin
        hit = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].vpn2 == tlb.entryhi[31:13]
                && (entries[i].g || entries[i].asid == tlb.entryhi[7:0])) begin
                hit = 1'b1;
                hit_idx = TLB_INDEX'(i);
            end
        end
    end

    always_comb begin
        tlb.resp.entryhi = {sel_entry.vpn2, 5'b0, sel_entry.asid};
        tlb.resp.entrylo0 = {6'b0, sel_entry.lo0, sel_entry.g};
        tlb.resp.entrylo1 = {6'b0, sel_entry.lo1, sel_entry.g};
        // miss sets P with index 0
        if (hit) begin
            tlb.resp.index = 32'(hit_idx);
        end else begin
            tlb.resp.index = 32'h8000_0000;
        end
    end

endmodule

/* source/cp0_subsystem.sv */
`timescale 1ns/1ns

module cp0_subsystem
    import cp0_pkg::*, tlb_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic [1:0] w_en,
    input creg_addr_t [1:0] w_addr,
    input logic [1:0][2:0] w_sel,
    input word_t [1:0] w_data,
    input creg_addr_t [1:0] r_addr,
    input logic [1:0][2:0] r_sel,
    output word_t [1:0] r_data,
    input logic exc_valid,
    input logic exc_delay_slot,
    input logic exc_cop1,
    input exc_code_t exc_code,
    input word_t exc_pc,
    input word_t exc_badvaddr,
    input logic is_eret,
    input tlb_op_t tlb_op,
    output word_t status,
    output word_t cause,
    output word_t epc,
    output logic timer_interrupt,
    output logic k0_uncached,
    output logic is_usermode,
    output logic bev_valid
);

    cp0_write_t [1:0] cwrite;
    exception_t exception;
    cp0_regs_t cp0_data;

    tlb_if tlb_bus ();

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cwrite[i].wen = w_en[i];
            cwrite[i].addr = w_addr[i];
            cwrite[i].sel = w_sel[i];
            cwrite[i].wd = w_data[i];
        end
    end

    assign exception.valid = exc_valid;
    assign exception.in_delay_slot = exc_delay_slot;
    assign exception.is_cop1 = exc_cop1;
    assign exception.code = exc_code;
    assign exception.pc = exc_pc;
    assign exception.badvaddr = exc_badvaddr;

    cp0 u_cp0 (
        .clk(clk),
        .reset(reset),
        .cwrite(cwrite),
        .r_addr(r_addr),
        .r_sel(r_sel),
        .r_data(r_data),
        .exception(exception),
        .is_eret(is_eret),
        .tlb_op(tlb_op),
        .cp0_data(cp0_data),
        .timer_interrupt(timer_interrupt),
        .k0_uncached(k0_uncached),
        .is_usermode(is_usermode),
        .bev_valid(bev_valid),
        .tlb(tlb_bus.cp0)
    );

    tlb u_tlb (
        .clk(clk),
        .reset(reset),
        .tlb(tlb_bus.tlb)
    );

    assign status = word_t'(cp0_data.status);
    assign cause = word_t'(cp0_data.cause);
    assign epc = cp0_data.epc;

endmodule

/* tests/cp0_subsystem_tb.sv */
`timescale 1ns/1ns

module cp0_subsystem_tb
    import cp0_pkg::*, tlb_pkg::*;
();

    localparam creg_addr_t REG_INDEX = 5'd0;
    localparam creg_addr_t REG_ENTRYLO0 = 5'd2;
    localparam creg_addr_t REG_ENTRYLO1 = 5'd3;
    localparam creg_addr_t REG_BADVADDR = 5'd8;
    localparam creg_addr_t REG_COUNT = 5'd9;
    localparam creg_addr_t REG_ENTRYHI = 5'd10;
    localparam creg_addr_t REG_COMPARE = 5'd11;
    localparam creg_addr_t REG_STATUS = 5'd12;
    localparam creg_addr_t REG_EPC = 5'd14;
    localparam creg_addr_t REG_CONFIG = 5'd16;
    // writable bits are cu0, bev, im, um, exl and ie
    localparam word_t STATUS_WMASK = 32'h1040_ff13;
    localparam word_t ENTRYHI_WMASK = 32'hffff_e0ff;
    localparam word_t ENTRYLO_WMASK = 32'h03ff_ffff;
    localparam word_t STATUS_AT_RESET = 32'h0040_0004;

    logic clk;
    logic reset;
    logic [1:0] w_en;
    creg_addr_t [1:0] w_addr;
    logic [1:0][2:0] w_sel;
    word_t [1:0] w_data;
    creg_addr_t [1:0] r_addr;
    logic [1:0][2:0] r_sel;
    word_t [1:0] r_data;
    logic exc_valid;
    logic exc_delay_slot;
    logic exc_cop1;
    exc_code_t exc_code;
    word_t exc_pc;
    word_t exc_badvaddr;
    logic is_eret;
    tlb_op_t tlb_op;
    word_t status;
    word_t cause;
    word_t epc;
    logic timer_interrupt;
    logic k0_uncached;
    logic is_usermode;
    logic bev_valid;

    int errors = 0;
    int checks = 0;
    word_t lfsr_state = 32'h8eff9c5e;
    word_t hi_w [TLB_ENTRIES];
    word_t lo0_w [TLB_ENTRIES];
    word_t lo1_w [TLB_ENTRIES];

    cp0_subsystem UUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic word_t galois_step(input word_t state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic word_t random_word();
        word_t value;
        value = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = galois_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_inputs();
        w_en = '0;
        w_addr = '0;
        w_sel = '0;
        w_data = '0;
        r_addr = '0;
        r_sel = '0;
        exc_valid = 1'b0;
        exc_delay_slot = 1'b0;
        exc_cop1 = 1'b0;
        exc_code = EXC_INT;
        exc_pc = '0;
        exc_badvaddr = '0;
        is_eret = 1'b0;
        tlb_op = TLB_NONE;
    endtask

    task automatic set_write(input logic slot, input creg_addr_t addr, input logic [2:0] sel,
                             input word_t data);
        w_en[slot] = 1'b1;
        w_addr[slot] = addr;
        w_sel[slot] = sel;
        w_data[slot] = data;
    endtask

    // one clock edge and then all strobes drop
    task automatic commit();
        tick();
        w_en = '0;
        exc_valid = 1'b0;
        is_eret = 1'b0;
        tlb_op = TLB_NONE;
    endtask

    task automatic expect_word(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_reg(input string name, input creg_addr_t addr, input logic [2:0] sel,
                              input word_t expected);
        r_addr = {addr, addr};
        r_sel = {sel, sel};
        #1;
        expect_word({name, " port0"}, expected, r_data[0]);
        expect_word({name, " port1"}, expected, r_data[1]);
    endtask

    task automatic read_word(input creg_addr_t addr, output word_t value);
        r_addr[0] = addr;
        r_sel[0] = 3'd0;
        #1;
        value = r_data[0];
    endtask

    task automatic write_entry(input logic [TLB_INDEX-1:0] e);
        hi_w[e] = random_word() & ENTRYHI_WMASK;
        lo0_w[e] = random_word() & ENTRYLO_WMASK;
        lo1_w[e] = random_word() & ENTRYLO_WMASK;
        // entry 5 is global and entry 2 never is
        if (e == 3'd5) begin
            lo0_w[e][0] = 1'b1;
            lo1_w[e][0] = 1'b1;
        end else if (e == 3'd2) begin
            lo0_w[e][0] = 1'b0;
        end
        set_write(1'b0, REG_INDEX, 3'd0, word_t'(e));
        set_write(1'b1, REG_ENTRYHI, 3'd0, hi_w[e]);
        commit();
        set_write(1'b0, REG_ENTRYLO0, 3'd0, lo0_w[e]);
        set_write(1'b1, REG_ENTRYLO1, 3'd0, lo1_w[e]);
        commit();
        tlb_op = TLB_WRITE_INDEXED;
        commit();
    endtask

    task automatic read_entry(input logic [TLB_INDEX-1:0] e);
        logic g;
        g = lo0_w[e][0] & lo1_w[e][0];
        set_write(1'b0, REG_INDEX, 3'd0, word_t'(e));
        set_write(1'b1, REG_ENTRYHI, 3'd0, '0);
        commit();
        tlb_op = TLB_READ;
        commit();
        expect_reg($sformatf("tlbr %0d entryhi", e), REG_ENTRYHI, 3'd0, hi_w[e]);
        expect_reg($sformatf("tlbr %0d entrylo0", e), REG_ENTRYLO0, 3'd0, {lo0_w[e][31:1], g});
        expect_reg($sformatf("tlbr %0d entrylo1", e), REG_ENTRYLO1, 3'd0, {lo1_w[e][31:1], g});
    endtask

    task automatic probe(input string name, input word_t hi, input word_t expected);
        set_write(1'b0, REG_ENTRYHI, 3'd0, hi);
        commit();
        tlb_op = TLB_PROBE;
        commit();
        expect_reg(name, REG_INDEX, 3'd0, expected);
    endtask

    task automatic wait_for_timer(input int limit, output bit seen);
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            tick();
            if (timer_interrupt) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: timer interrupt did not rise within %0d cycles", limit);
        end
    endtask

    initial begin
        word_t v;
        word_t a;
        word_t pc;
        word_t bva;
        word_t c1;
        word_t c2;
        word_t cmp;
        bit seen;

        clear_inputs();
        reset = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b1;
        expect_word("reset timer", 0, word_t'(timer_interrupt));
        expect_word("reset usermode", 0, word_t'(is_usermode));
        expect_word("reset bev", 1, word_t'(bev_valid));
        expect_word("reset k0", 0, word_t'(k0_uncached));
        expect_word("reset status", STATUS_AT_RESET, status);

        // write masking and port priority
        v = random_word();
        set_write(1'b0, REG_EPC, 3'd0, v);
        commit();
        expect_reg("write epc", REG_EPC, 3'd0, v);
        v = random_word();
        set_write(1'b1, REG_COMPARE, 3'd0, v);
        commit();
        expect_reg("write compare", REG_COMPARE, 3'd0, v);
        v = random_word();
        set_write(1'b0, REG_STATUS, 3'd0, v);
        commit();
        expect_reg("write status", REG_STATUS, 3'd0,
                   (STATUS_AT_RESET & ~STATUS_WMASK) | (v & STATUS_WMASK));
        v = random_word();
        set_write(1'b1, REG_ENTRYHI, 3'd0, v);
        commit();
        expect_reg("write entryhi", REG_ENTRYHI, 3'd0, v & ENTRYHI_WMASK);
        a = random_word();
        set_write(1'b0, REG_EPC, 3'd0, a);
        set_write(1'b1, REG_EPC, 3'd0, random_word());
        commit();
        expect_reg("slot priority", REG_EPC, 3'd0, a);
        set_write(1'b0, REG_EPC, 3'd1, random_word());
        commit();
        expect_reg("sel 1 write", REG_EPC, 3'd0, a);
        expect_reg("config1", REG_CONFIG, 3'd1, word_t'(TLB_ENTRIES - 1) << 25);

        // exception recording starts with exl clear
        set_write(1'b0, REG_STATUS, 3'd0, 32'h0040_0000);
        commit();
        pc = random_word();
        bva = random_word();
        exc_valid = 1'b1;
        exc_delay_slot = 1'b1;
        exc_code = EXC_ADEL;
        exc_pc = pc;
        exc_badvaddr = bva;
        commit();
        expect_word("exc epc", pc - 32'd4, epc);
        expect_word("exc bd", 1, word_t'(cause[31]));
        expect_word("exc code", 4, word_t'(cause[6:2]));
        expect_word("exc exl", 1, word_t'(status[1]));
        expect_reg("exc badvaddr", REG_BADVADDR, 3'd0, bva);
        exc_valid = 1'b1;
        exc_delay_slot = 1'b0;
        exc_code = EXC_SYS;
        exc_pc = random_word();
        commit();
        expect_reg("nested epc", REG_EPC, 3'd0, pc - 32'd4);
        expect_word("nested code", 8, word_t'(cause[6:2]));

        // eret and mode outputs
        set_write(1'b0, REG_STATUS, 3'd0, 32'h0040_0010);
        commit();
        expect_word("um with erl", 0, word_t'(is_usermode));
        set_write(1'b0, REG_STATUS, 3'd0, 32'h0040_0012);
        commit();
        is_eret = 1'b1;
        commit();
        expect_word("eret1 erl", 0, word_t'(status[2]));
        expect_word("eret1 exl", 1, word_t'(status[1]));
        expect_word("um with exl", 0, word_t'(is_usermode));
        is_eret = 1'b1;
        commit();
        expect_word("eret2 exl", 0, word_t'(status[1]));
        expect_word("um clear", 1, word_t'(is_usermode));
        set_write(1'b0, REG_STATUS, 3'd0, 32'h0000_0010);
        commit();
        expect_word("bev off", 0, word_t'(bev_valid));
        set_write(1'b1, REG_STATUS, 3'd0, 32'h0040_0000);
        commit();
        expect_word("bev on", 1, word_t'(bev_valid));
        expect_word("um off", 0, word_t'(is_usermode));
        set_write(1'b0, REG_CONFIG, 3'd0, 32'h2);
        commit();
        expect_word("k0 uncached", 1, word_t'(k0_uncached));
        set_write(1'b0, REG_CONFIG, 3'd0, 32'h3);
        commit();
        expect_word("k0 cached", 0, word_t'(k0_uncached));

        // tlb write, read back and probe
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            write_entry(TLB_INDEX'(i));
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            read_entry(TLB_INDEX'(i));
        end
        probe("probe hit", hi_w[3], 32'd3);
        probe("probe asid miss", {hi_w[2][31:8], ~hi_w[2][7:0]}, 32'h8000_0000);
        probe("probe global", {hi_w[5][31:8], ~hi_w[5][7:0]}, 32'd5);

        // timer
        read_word(REG_COUNT, c1);
        repeat (20) tick();
        read_word(REG_COUNT, c2);
        expect_word("count rate", 32'd10, c2 - c1);
        read_word(REG_COUNT, c1);
        cmp = c1 + 32'd20;
        set_write(1'b0, REG_COMPARE, 3'd0, cmp);
        commit();
        expect_word("timer idle", 0, word_t'(timer_interrupt));
        wait_for_timer(60, seen);
        if (seen) begin
            read_word(REG_COUNT, c2);
            checks++;
            assert (c2 == cmp || c2 == cmp + 32'd1) else begin
                errors++;
                $display("** Error timer count: expected %h or %h, actual %h",
                         cmp, cmp + 32'd1, c2);
            end
        end
        repeat (4) tick();
        expect_word("timer hold", 1, word_t'(timer_interrupt));
        set_write(1'b1, REG_COMPARE, 3'd0, cmp + 32'd1000);
        commit();
        expect_word("timer clear", 0, word_t'(timer_interrupt));

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* cp0_subsystem.f */
source/cp0_pkg.sv
source/tlb_pkg.sv
source/tlb_if.sv
source/cp0.sv
source/tlb.sv
source/cp0_subsystem.sv
tests/cp0_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cp0 subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module cp0_subsystem_tb -f cp0_subsystem.f -o cp0_subsystem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cp0_subsystem_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
exit 1
